// File: source/memIssueTypes.sv
/*
  Shared types, constants and the selective flush rule for the memory issue
  subsystem. Modules take what they need through a wildcard import.
*/
`default_nettype none

package memIssueTypes;

    // Active list position that wraps circularly
    typedef logic [3:0] activeListPtrT;
    typedef logic [1:0] queuePtrT;
    // Op kinds are load 0, store 1 and divide 2
    typedef logic [1:0] opTypeT;
    typedef logic [7:0] payloadT;

    localparam int queueDepth = 4;
    // Cycles the shared divider stays busy after an acquire
    localparam int divLockCycles = 5;
    localparam opTypeT opTypeDiv = 2'd2;

    typedef enum logic [1:0] {
        recoveryIdle,
        recoveryFlush,
        recoveryDrain
    } recoveryStateT;

    // True when ptr lies in the half-open range [head, tail) during recovery
    function automatic logic inFlushRange(
        input logic          toRecoveryPhase,
        input activeListPtrT head,
        input activeListPtrT tail,
        input logic          flushAll,
        input activeListPtrT ptr
    );
        activeListPtrT ptrDist;
        activeListPtrT rangeDist;
        ptrDist = ptr - head;
        rangeDist = tail - head;
        return toRecoveryPhase && (flushAll || (ptrDist < rangeDist));
    endfunction

endpackage

`default_nettype wire

// File: source/divLockTimer.sv
/*
  Busy timer for the shared divider. An acquire reloads the count and the
  divider reads as busy until it reaches zero.
*/
`timescale 1ns/1ps
`default_nettype none

module divLockTimer
    import memIssueTypes::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic divAcquire,
    output logic      divBusy
);

    localparam int countWidth = $clog2(divLockCycles + 1);

    logic [countWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (divAcquire) begin
            count <= countWidth'(divLockCycles);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Busy for exactly divLockCycles cycles after the acquire edge
    assign divBusy = count != '0;

endmodule

`default_nettype wire

// File: source/recoveryManager.sv
/*
  Recovery control for selective flushes. Latches the flushed active-list
  range, raises the recovery phase for one cycle and blocks dispatch until a
  drain cycle has passed.
*/
`timescale 1ns/1ps
`default_nettype none

module recoveryManager
    import memIssueTypes::*;
(
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          flushReq,
    input  wire activeListPtrT flushHead,
    input  wire activeListPtrT flushTail,
    input  wire logic          flushAll,
    output logic               toRecoveryPhase,
    output activeListPtrT      rangeHead,
    output activeListPtrT      rangeTail,
    output logic               rangeAll,
    output logic               dispatchBlock
);

    recoveryStateT state;
    recoveryStateT nextState;
    logic accept;

    // Requests are only taken while idle
    assign accept = flushReq && state == recoveryIdle;

    always_comb begin
        nextState = state;
        case (state)
            recoveryIdle: begin
                if (flushReq) begin
                    nextState = recoveryFlush;
                end
            end
            recoveryFlush: begin
                nextState = recoveryDrain;
            end
            recoveryDrain: begin
                nextState = recoveryIdle;
            end
            default: begin
                nextState = recoveryIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= recoveryIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rangeHead <= flushHead;
            rangeTail <= flushTail;
            rangeAll <= flushAll;
        end
    end

    assign toRecoveryPhase = state == recoveryFlush;
    // Covers both the flush and the drain cycle
    assign dispatchBlock = state != recoveryIdle;

endmodule

`default_nettype wire

// File: source/memIssueQueue.sv
/*
  Four-entry memory issue queue. Ops are written in program order, the oldest
  unselected one is offered to the issue stage, and entries are freed on issue
  or by a selective flush. Age ranks are compacted whenever entries leave.
*/
`timescale 1ns/1ps
`default_nettype none

module memIssueQueue
    import memIssueTypes::*;
(
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          dispatchValid,
    input  wire activeListPtrT dispatchPtr,
    input  wire opTypeT        dispatchType,
    input  wire payloadT       dispatchPayload,
    output logic               queueFull,
    input  wire logic          stageStall,
    input  wire logic          issueStrobe,
    input  wire queuePtrT      issuePtr,
    input  wire logic          toRecoveryPhase,
    input  wire activeListPtrT rangeHead,
    input  wire activeListPtrT rangeTail,
    input  wire logic          rangeAll,
    output logic               selValid,
    output queuePtrT           selPtr,
    output activeListPtrT      selAlPtr,
    output opTypeT             selType,
    output payloadT            selPayload
);

    logic          entValid    [queueDepth];
    logic          entSelected [queueDepth];
    queuePtrT      entRank     [queueDepth];
    activeListPtrT entAlPtr    [queueDepth];
    opTypeT        entType     [queueDepth];
    payloadT       entPayload  [queueDepth];

    logic     keep    [queueDepth];
    queuePtrT newRank [queueDepth];
    logic [2:0] numKept;
    logic     freeFound;
    queuePtrT freeIdx;
    logic     dispatchWrite;
    logic     markSel;
    queuePtrT bestRank;

    always_comb begin
        queueFull = 1'b1;
        for (int i = 0; i < queueDepth; i++) begin
            queueFull = queueFull && entValid[i];
        end
    end

    // Oldest valid entry not yet handed to the stage
    always_comb begin
        selValid = 1'b0;
        selPtr = '0;
        bestRank = '0;
        for (int i = 0; i < queueDepth; i++) begin
            if (entValid[i] && !entSelected[i] && (!selValid || entRank[i] < bestRank)) begin
                selValid = 1'b1;
                selPtr = queuePtrT'(i);
                bestRank = entRank[i];
            end
        end
        selAlPtr = entAlPtr[selPtr];
        selType = entType[selPtr];
        selPayload = entPayload[selPtr];
    end

    // Release on issue or flush, then compact ranks
    always_comb begin
        numKept = '0;
        for (int i = 0; i < queueDepth; i++) begin
            keep[i] = entValid[i]
                && !(issueStrobe && issuePtr == queuePtrT'(i))
                && !inFlushRange(toRecoveryPhase, rangeHead, rangeTail, rangeAll,
                                 entAlPtr[i]);
            numKept = numKept + {2'b00, keep[i]};
        end
        for (int i = 0; i < queueDepth; i++) begin
            newRank[i] = '0;
            for (int j = 0; j < queueDepth; j++) begin
                if (keep[j] && entRank[j] < entRank[i]) begin
                    newRank[i] = newRank[i] + 1'b1;
                end
            end
        end
    end

    // Lowest empty slot takes the next dispatch
    always_comb begin
        freeFound = 1'b0;
        freeIdx = '0;
        for (int i = queueDepth - 1; i >= 0; i--) begin
            if (!entValid[i]) begin
                freeFound = 1'b1;
                freeIdx = queuePtrT'(i);
            end
        end
    end

    assign dispatchWrite = dispatchValid && freeFound;
    assign markSel = selValid && !stageStall;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < queueDepth; i++) begin
                entValid[i] <= 1'b0;
                entSelected[i] <= 1'b0;
                entRank[i] <= '0;
            end
        end else begin
            for (int i = 0; i < queueDepth; i++) begin
                if (dispatchWrite && freeIdx == queuePtrT'(i)) begin
                    entValid[i] <= 1'b1;
                    entSelected[i] <= 1'b0;
                    // Youngest op ranks behind every survivor
                    entRank[i] <= queuePtrT'(numKept);
                end else begin
                    entValid[i] <= keep[i];
                    entSelected[i] <= keep[i]
                        && (entSelected[i] || (markSel && selPtr == queuePtrT'(i)));
                    entRank[i] <= newRank[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatchWrite) begin
            entAlPtr[freeIdx] <= dispatchPtr;
            entType[freeIdx] <= dispatchType;
            entPayload[freeIdx] <= dispatchPayload;
        end
    end

endmodule

`default_nettype wire

// File: source/memIssueStage.sv
/*
  One-lane memory issue stage. Holds the op picked by the queue, makes the
  final issue decision against stall, divider lock and flush, and registers
  the issued op toward register read.
*/
`timescale 1ns/1ps
`default_nettype none

module memIssueStage
    import memIssueTypes::*;
(
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          stall,
    input  wire logic          selValid,
    input  wire queuePtrT      selPtr,
    input  wire activeListPtrT selAlPtr,
    input  wire opTypeT        selType,
    input  wire payloadT       selPayload,
    output logic               stageStall,
    input  wire logic          toRecoveryPhase,
    input  wire activeListPtrT rangeHead,
    input  wire activeListPtrT rangeTail,
    input  wire logic          rangeAll,
    input  wire logic          divBusy,
    output logic               issueStrobe,
    output queuePtrT           issuePtr,
    output logic               divAcquire,
    output logic               memOutValid,
    output activeListPtrT      memOutPtr,
    output opTypeT             memOutType,
    output payloadT            memOutPayload
);

    logic          stValid;
    queuePtrT      stQPtr;
    activeListPtrT stAlPtr;
    opTypeT        stType;
    payloadT       stPayload;

    logic flushHit;
    logic selFlushHit;
    logic issue;

    assign flushHit = inFlushRange(toRecoveryPhase, rangeHead, rangeTail, rangeAll, stAlPtr);
    assign selFlushHit = inFlushRange(toRecoveryPhase, rangeHead, rangeTail, rangeAll,
                                      selAlPtr);

    // Divide waits here until the shared divider frees up
    assign stageStall = stall || (stValid && stType == opTypeDiv && divBusy);

    assign issue = stValid && !stageStall && !flushHit;
    assign issueStrobe = issue;
    assign issuePtr = stQPtr;
    assign divAcquire = issue && stType == opTypeDiv;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stValid <= 1'b0;
        end else if (!stageStall) begin
            stValid <= selValid && !selFlushHit;
        end else begin
            stValid <= stValid && !flushHit;
        end
    end

    always_ff @(posedge clk) begin
        if (!stageStall) begin
            stQPtr <= selPtr;
            stAlPtr <= selAlPtr;
            stType <= selType;
            stPayload <= selPayload;
        end
    end

    // Register read side
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memOutValid <= 1'b0;
        end else begin
            memOutValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            memOutPtr <= stAlPtr;
            memOutType <= stType;
            memOutPayload <= stPayload;
        end
    end

endmodule

`default_nettype wire

// File: source/memIssueTop.sv
/*
  Top of the memory issue subsystem. Wires the issue queue, the issue stage,
  the recovery manager and the divider lock timer together.
*/
`timescale 1ns/1ps
`default_nettype none

module memIssueTop
    import memIssueTypes::*;
(
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          stall,
    input  wire logic          dispatchValid,
    input  wire activeListPtrT dispatchPtr,
    input  wire opTypeT        dispatchType,
    input  wire payloadT       dispatchPayload,
    output logic               queueFull,
    output logic               dispatchBlock,
    input  wire logic          flushReq,
    input  wire activeListPtrT flushHead,
    input  wire activeListPtrT flushTail,
    input  wire logic          flushAll,
    output logic               memOutValid,
    output activeListPtrT      memOutPtr,
    output opTypeT             memOutType,
    output payloadT            memOutPayload
);

    logic          selValid;
    queuePtrT      selPtr;
    activeListPtrT selAlPtr;
    opTypeT        selType;
    payloadT       selPayload;
    logic          stageStall;
    logic          issueStrobe;
    queuePtrT      issuePtr;
    logic          divAcquire;
    logic          divBusy;
    logic          toRecoveryPhase;
    activeListPtrT rangeHead;
    activeListPtrT rangeTail;
    logic          rangeAll;
    logic          dispatchAccept;

    // Dispatch offered during recovery is dropped
    assign dispatchAccept = dispatchValid && !dispatchBlock;

    memIssueQueue queue (
        .clk, .rstN,
        .dispatchValid(dispatchAccept),
        .dispatchPtr, .dispatchType, .dispatchPayload, .queueFull,
        .stageStall, .issueStrobe, .issuePtr,
        .toRecoveryPhase, .rangeHead, .rangeTail, .rangeAll,
        .selValid, .selPtr, .selAlPtr, .selType, .selPayload
    );

    memIssueStage stage (
        .clk, .rstN, .stall,
        .selValid, .selPtr, .selAlPtr, .selType, .selPayload,
        .stageStall,
        .toRecoveryPhase, .rangeHead, .rangeTail, .rangeAll,
        .divBusy, .issueStrobe, .issuePtr, .divAcquire,
        .memOutValid, .memOutPtr, .memOutType, .memOutPayload
    );

    recoveryManager recovery (
        .clk, .rstN,
        .flushReq, .flushHead, .flushTail, .flushAll,
        .toRecoveryPhase, .rangeHead, .rangeTail, .rangeAll, .dispatchBlock
    );

    divLockTimer divTimer (
        .clk, .rstN, .divAcquire, .divBusy
    );

endmodule

`default_nettype wire

// File: tests/memIssueTb.sv
/*
  Testbench for the memory issue subsystem. Runs the commands in
  tests/memIssueVectors.txt and keeps a reference list of ops in flight.
  The list is trimmed on every flush and checked against each output.
*/
`timescale 1ns/1ps
`default_nettype none

module memIssueTb
    import memIssueTypes::*;
();

    localparam int timeoutCycles = 200;

    typedef struct packed {
        activeListPtrT alPtr;
        opTypeT        kind;
        payloadT       payload;
    } expectedOpT;

    logic          clk;
    logic          rstN;
    logic          stall;
    logic          dispatchValid;
    activeListPtrT dispatchPtr;
    opTypeT        dispatchType;
    payloadT       dispatchPayload;
    logic          queueFull;
    logic          dispatchBlock;
    logic          flushReq;
    activeListPtrT flushHead;
    activeListPtrT flushTail;
    logic          flushAll;
    logic          memOutValid;
    activeListPtrT memOutPtr;
    opTypeT        memOutType;
    payloadT       memOutPayload;

    // Ops dispatched and not yet seen at the output in age order
    expectedOpT pendingOps[$];
    int stallLeft;
    int cycleNo;
    int lastDivCycle;

    memIssueTop UUT (.*);

    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Half-open range from head to tail measured around the 16-entry circle
    function automatic logic flushCovers(input activeListPtrT head, input activeListPtrT tail,
                                         input logic wholeRange, input activeListPtrT ptr);
        int offset;
        int span;
        offset = (int'(ptr) - int'(head) + 16) % 16;
        span = (int'(tail) - int'(head) + 16) % 16;
        return wholeRange || offset < span;
    endfunction

    task automatic checkOutput();
        expectedOpT exp;
        if (memOutValid) begin
            if (pendingOps.size() == 0) begin
                abortRun("an op came out while none was expected");
            end else begin
                exp = pendingOps.pop_front();
                checkValue("memOutPtr", memOutPtr, exp.alPtr);
                checkValue("memOutType", memOutType, exp.kind);
                checkValue("memOutPayload", memOutPayload, exp.payload);
                if (exp.kind == opTypeDiv) begin
                    if (lastDivCycle >= 0 && cycleNo - lastDivCycle < divLockCycles + 1) begin
                        abortRun($sformatf("two divides came out only %0d cycles apart",
                                           cycleNo - lastDivCycle));
                    end
                    lastDivCycle = cycleNo;
                end
            end
        end
    endtask

    // Rising edge drops the strobes and steps the stall counter
    task automatic driveEdge();
        @(posedge clk);
        cycleNo++;
        dispatchValid <= 1'b0;
        flushReq <= 1'b0;
        if (stallLeft > 0) begin
            stall <= 1'b1;
            stallLeft--;
        end else begin
            stall <= 1'b0;
        end
    endtask

    task automatic sampleEdge();
        @(negedge clk);
        checkOutput();
    endtask

    task automatic idleCycle();
        driveEdge();
        sampleEdge();
    endtask

    task automatic dispatchOp(input activeListPtrT ptr, input opTypeT kind, input payloadT data);
        int waited;
        logic taken;
        expectedOpT rec;
        waited = 0;
        taken = 1'b0;
        while (!taken) begin
            if (queueFull || dispatchBlock) begin
                idleCycle();
            end else begin
                driveEdge();
                dispatchValid <= 1'b1;
                dispatchPtr <= ptr;
                dispatchType <= kind;
                dispatchPayload <= data;
                sampleEdge();
                // Taken only if both levels stayed low while the strobe was up
                taken = !queueFull && !dispatchBlock;
            end
            waited++;
            if (!taken && waited > timeoutCycles) begin
                abortRun("timed out waiting for the queue to accept a dispatch");
            end
        end
        rec.alPtr = ptr;
        rec.kind = kind;
        rec.payload = data;
        pendingOps.push_back(rec);
    endtask

    task automatic dropFlushed(input activeListPtrT head, input activeListPtrT tail,
                               input logic wholeRange);
        expectedOpT kept[$];
        foreach (pendingOps[i]) begin
            if (!flushCovers(head, tail, wholeRange, pendingOps[i].alPtr)) begin
                kept.push_back(pendingOps[i]);
            end
        end
        pendingOps = kept;
    endtask

    task automatic flushOps(input activeListPtrT head, input activeListPtrT tail,
                            input logic wholeRange);
        int waited;
        waited = 0;
        while (dispatchBlock) begin
            idleCycle();
            waited++;
            if (waited > timeoutCycles) begin
                abortRun("timed out waiting for the recovery manager to go idle");
            end
        end
        driveEdge();
        flushReq <= 1'b1;
        flushHead <= head;
        flushTail <= tail;
        flushAll <= wholeRange;
        sampleEdge();
        checkValue("dispatchBlock", dispatchBlock, 1'b0);
        idleCycle();
        checkValue("dispatchBlock", dispatchBlock, 1'b1);
        driveEdge();
        // Ops out by now were issued before the recovery phase
        dropFlushed(head, tail, wholeRange);
        sampleEdge();
        checkValue("dispatchBlock", dispatchBlock, 1'b1);
        idleCycle();
        checkValue("dispatchBlock", dispatchBlock, 1'b0);
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (pendingOps.size() != 0) begin
            idleCycle();
            waited++;
            if (waited > timeoutCycles) begin
                abortRun("timed out waiting for the expected ops to come out");
            end
        end
    endtask

    task automatic skipLine(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    initial begin
        int fd;
        int code;
        logic [7:0] cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        dispatchValid = 1'b0;
        dispatchPtr = '0;
        dispatchType = '0;
        dispatchPayload = '0;
        flushReq = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
        stallLeft = 0;
        cycleNo = 0;
        lastDivCycle = -1;
        fd = $fopen("tests/memIssueVectors.txt", "r");
        if (fd == 0) begin
            abortRun("could not open tests/memIssueVectors.txt");
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": skipLine(fd);
                "D": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    if (code != 3) begin
                        abortRun("a dispatch line in the vectors file has missing fields");
                    end
                    dispatchOp(f1[3:0], f2[1:0], f3[7:0]);
                end
                "S": begin
                    code = $fscanf(fd, "%h", f1);
                    if (code != 1) begin
                        abortRun("a stall line in the vectors file has no cycle count");
                    end
                    stallLeft = f1;
                end
                "F": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    if (code != 3) begin
                        abortRun("a flush line in the vectors file has missing fields");
                    end
                    flushOps(f1[3:0], f2[3:0], f3[0]);
                end
                "Q": begin
                    code = $fscanf(fd, "%h", f1);
                    if (code != 1) begin
                        abortRun("a queue full line in the vectors file has no value");
                    end
                    idleCycle();
                    checkValue("queueFull", queueFull, f1[0]);
                end
                "W": drainOutputs();
                default: abortRun($sformatf("unknown command '%c' in the vectors file", cmd));
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);
        drainOutputs();
        // A few quiet cycles to catch any stray output
        repeat (10) idleCycle();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/memIssueTypes.sv
source/divLockTimer.sv
source/recoveryManager.sv
source/memIssueQueue.sv
source/memIssueStage.sv
source/memIssueTop.sv
tests/memIssueTb.sv

// File: tests/memIssueVectors.txt
# D alPtr type payload | S stallCycles | F head tail all | Q queueFull | W drain
# All fields hex; type 0 load, 1 store, 2 divide
# Order and content
D 0 0 a1
D 1 1 b2
D 2 0 c3
D 3 1 d4
W
# Queue full under stall, the fifth dispatch waits for room
S 0c
D 4 0 11
D 5 1 22
D 6 0 33
D 7 1 44
Q 1
D 8 0 55
W
# Selective flush, second divide held in the stage by the lock
D 9 2 61
D a 2 62
D b 0 63
D c 1 64
F a c 0
W
# Full flush with one op held in the stage by stall
D d 0 71
Q 0
S 14
D e 1 72
D f 0 73
F 0 0 1
D 0 1 74
D 1 0 75
W
# Divider lock, a load between two divides, then divides back to back
D 2 2 81
D 3 0 82
D 4 2 83
D 5 2 84
D 6 2 85
W
# Flush range that wraps past the end of the active list
S 0f
D e 0 91
D f 1 92
D 0 0 93
D 1 1 94
F f 1 0
W
